//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_csr_unit
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
hw/csr_pkg.sv
hw/csr_op_unit.sv
hw/csr_regfile.sv
hw/cycle_counter.sv
hw/trap_fsm.sv
hw/csr_unit.sv
verification/tb_csr_unit.sv

//--- hw/csr_op_unit.sv
`default_nettype none
`timescale 1ns/100ps

module csr_op_unit
    import csr_pkg::*;
(
    input  logic    csr_valid,
    input  csr_op_t csr_op,
    input  xlen_t   csr_operand,
    input  xlen_t   old_value,
    output logic    wr_en,
    output xlen_t   wr_data
);

    logic operand_zero;

    assign operand_zero = (csr_operand == '0);

    always_comb begin
        wr_en   = 1'b0;
        wr_data = old_value;
        case (csr_op)
            csr_op_write: begin
                wr_en   = csr_valid;
                wr_data = csr_operand;
            end
            csr_op_set: begin
                wr_en   = csr_valid && !operand_zero; // Pure read otherwise.
                wr_data = old_value | csr_operand;
            end
            csr_op_clear: begin
                wr_en   = csr_valid && !operand_zero;
                wr_data = old_value & ~csr_operand;
            end
            default: begin
                wr_en   = 1'b0;
                wr_data = old_value;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;

    // Resolved operation, immediate forms arrive with the same encoding.
    typedef enum logic [1:0] {
        csr_op_none  = 2'd0,
        csr_op_write = 2'd1,
        csr_op_set   = 2'd2,
        csr_op_clear = 2'd3
    } csr_op_t;

    localparam csr_addr_t csr_mstatus  = 12'h300;
    localparam csr_addr_t csr_mtvec    = 12'h305;
    localparam csr_addr_t csr_mscratch = 12'h340;
    localparam csr_addr_t csr_mepc     = 12'h341;
    localparam csr_addr_t csr_mcause   = 12'h342;
    localparam csr_addr_t csr_mcycle   = 12'hB00;
    localparam csr_addr_t csr_mcycleh  = 12'hB80;

    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;

    localparam xlen_t mstatus_fixed = 32'h0000_1800; // MPP is machine mode.
    localparam xlen_t cause_ecall_m = 32'd11;

    typedef enum logic [1:0] {
        state_idle     = 2'd0,
        state_save     = 2'd1,
        state_redirect = 2'd2
    } trap_state_t;

endpackage

`default_nettype wire

//--- hw/csr_regfile.sv
`default_nettype none
`timescale 1ns/100ps

module csr_regfile
    import csr_pkg::*;
#(
    parameter xlen_t reset_mtvec = '0
) (
    input  logic        clk,
    input  logic        rst,
    input  csr_addr_t   csr_addr,
    input  logic        wr_en,
    input  xlen_t       wr_data,
    input  logic        trap_save,
    input  logic        trap_return,
    input  xlen_t       trap_pc,
    input  logic [63:0] cycle_count,
    output xlen_t       rdata,
    output logic        illegal,
    output xlen_t       mtvec,
    output xlen_t       mepc
);

    logic  mie_q;
    logic  mpie_q;
    xlen_t mtvec_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t mscratch_q;
    xlen_t mstatus_value;

    logic  wr_mstatus;
    logic  wr_mtvec;
    logic  wr_mepc;
    logic  wr_mscratch;

    always_comb begin
        mstatus_value                   = mstatus_fixed;
        mstatus_value[mstatus_mie_bit]  = mie_q;
        mstatus_value[mstatus_mpie_bit] = mpie_q;
    end

    always_comb begin
        illegal = 1'b0;
        case (csr_addr)
            csr_mstatus:  rdata = mstatus_value;
            csr_mtvec:    rdata = mtvec_q;
            csr_mepc:     rdata = mepc_q;
            csr_mcause:   rdata = mcause_q;
            csr_mscratch: rdata = mscratch_q;
            csr_mcycle:   rdata = cycle_count[31:0];
            csr_mcycleh:  rdata = cycle_count[63:32];
            default: begin
                rdata   = '0;
                illegal = 1'b1;
            end
        endcase
    end

    // mcause is left to the trap path.
    assign wr_mstatus  = wr_en && (csr_addr == csr_mstatus);
    assign wr_mtvec    = wr_en && (csr_addr == csr_mtvec);
    assign wr_mepc     = wr_en && (csr_addr == csr_mepc);
    assign wr_mscratch = wr_en && (csr_addr == csr_mscratch);

    always_ff @(posedge clk) begin
        if (rst) begin
            mie_q      <= 1'b0;
            mpie_q     <= 1'b0;
            mtvec_q    <= reset_mtvec;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mscratch_q <= '0;
        end else begin
            if (trap_save) begin
                mepc_q   <= trap_pc;
                mcause_q <= cause_ecall_m;
                mpie_q   <= mie_q;  // Stack the enable.
                mie_q    <= 1'b0;
            end else if (trap_return) begin
                mie_q  <= mpie_q;
                mpie_q <= 1'b1;
            end else begin
                if (wr_mstatus) begin
                    mie_q  <= wr_data[mstatus_mie_bit];
                    mpie_q <= wr_data[mstatus_mpie_bit];
                end
                if (wr_mepc) begin
                    mepc_q <= wr_data;
                end
            end
            if (wr_mtvec) begin
                mtvec_q <= wr_data;
            end
            if (wr_mscratch) begin
                mscratch_q <= wr_data;
            end
        end
    end

    assign mtvec = mtvec_q;
    assign mepc  = mepc_q;

endmodule

`default_nettype wire

//--- hw/csr_unit.sv
`default_nettype none
`timescale 1ns/100ps

module csr_unit
    import csr_pkg::*;
#(
    parameter xlen_t reset_mtvec = '0
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      csr_valid,
    input  csr_addr_t csr_addr,
    input  csr_op_t   csr_op,
    input  xlen_t     csr_operand,
    input  logic      ecall,
    input  logic      mret,
    input  xlen_t     pc,
    output xlen_t     csr_rdata,
    output logic      csr_illegal,
    output logic      busy,
    output logic      redirect_valid,
    output xlen_t     redirect_pc
);

    logic        op_valid;
    logic        wr_en;
    xlen_t       wr_data;
    logic        trap_save;
    logic        trap_return;
    xlen_t       mtvec;
    xlen_t       mepc;
    xlen_t       trap_pc_q;
    logic [63:0] cycle_count;

    assign op_valid = csr_valid && !busy; // Strobes during a trap are dropped.

    // Hold the ecall pc until the save cycle.
    always_ff @(posedge clk) begin
        if (ecall && !busy) begin
            trap_pc_q <= pc;
        end
    end

    csr_op_unit csr_op_unit_inst (
        .csr_valid   (op_valid),
        .csr_op      (csr_op),
        .csr_operand (csr_operand),
        .old_value   (csr_rdata),
        .wr_en       (wr_en),
        .wr_data     (wr_data)
    );

    csr_regfile #(
        .reset_mtvec (reset_mtvec)
    ) csr_regfile_inst (
        .clk         (clk),
        .rst         (rst),
        .csr_addr    (csr_addr),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .trap_save   (trap_save),
        .trap_return (trap_return),
        .trap_pc     (trap_pc_q),
        .cycle_count (cycle_count),
        .rdata       (csr_rdata),
        .illegal     (csr_illegal),
        .mtvec       (mtvec),
        .mepc        (mepc)
    );

    cycle_counter cycle_counter_inst (
        .clk      (clk),
        .rst      (rst),
        .csr_addr (csr_addr),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .count    (cycle_count)
    );

    trap_fsm trap_fsm_inst (
        .clk            (clk),
        .rst            (rst),
        .ecall          (ecall),
        .mret           (mret),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .trap_save      (trap_save),
        .trap_return    (trap_return),
        .busy           (busy),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

//--- hw/cycle_counter.sv
`default_nettype none
`timescale 1ns/100ps

module cycle_counter
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  csr_addr_t   csr_addr,
    input  logic        wr_en,
    input  xlen_t       wr_data,
    output logic [63:0] count
);

    logic        wr_low;
    logic        wr_high;
    logic [63:0] count_q;

    assign wr_low  = wr_en && (csr_addr == csr_mcycle);
    assign wr_high = wr_en && (csr_addr == csr_mcycleh);

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (wr_low) begin
            count_q[31:0] <= wr_data;    // No increment on a write.
        end else if (wr_high) begin
            count_q[63:32] <= wr_data;
        end else begin
            count_q <= count_q + 64'd1;
        end
    end

    assign count = count_q;

endmodule

`default_nettype wire

//--- hw/trap_fsm.sv
`default_nettype none
`timescale 1ns/100ps

module trap_fsm
    import csr_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  ecall,
    input  logic  mret,
    input  xlen_t mtvec,
    input  xlen_t mepc,
    output logic  trap_save,
    output logic  trap_return,
    output logic  busy,
    output logic  redirect_valid,
    output xlen_t redirect_pc
);

    trap_state_t state_q;
    trap_state_t state_d;
    logic        is_mret_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            state_idle: begin
                if (ecall || mret) begin
                    state_d = state_save;
                end
            end
            state_save: begin
                state_d = state_redirect;
            end
            state_redirect: begin
                state_d = state_idle;
            end
            default: begin
                state_d = state_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= state_idle;
            is_mret_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == state_idle && (ecall || mret)) begin
                is_mret_q <= mret && !ecall; // ecall wins a collision.
            end
        end
    end

    assign busy           = (state_q != state_idle);
    assign trap_save      = (state_q == state_save) && !is_mret_q;
    assign trap_return    = (state_q == state_save) && is_mret_q;
    assign redirect_valid = (state_q == state_redirect);

    // Registers already hold the committed values here.
    assign redirect_pc = is_mret_q ? mepc : {mtvec[31:2], 2'b00};

endmodule

`default_nettype wire

//--- verification/csr_patterns.txt
# kind addr op operand pc exp_rdata exp_illegal exp_redirect_pc, numbers in hex
# op: 0 none, 1 write, 2 set, 3 clear
csr   b00 0 00000000 00000000 00000000 0 00000000
csr   b00 1 00001000 00000000 00000001 0 00000000
csr   b00 0 00000000 00000000 00001000 0 00000000
idle  000 0 00000000 00000000 00000000 0 00000000
idle  000 0 00000000 00000000 00000000 0 00000000
csr   b00 0 00000000 00000000 00001003 0 00000000
csr   b80 1 a5a50001 00000000 00000000 0 00000000
csr   b80 0 00000000 00000000 a5a50001 0 00000000
csr   b00 0 00000000 00000000 00001005 0 00000000
csr   b00 1 ffffffff 00000000 00001006 0 00000000
csr   b00 0 00000000 00000000 ffffffff 0 00000000
csr   b80 0 00000000 00000000 a5a50002 0 00000000
csr   b00 0 00000000 00000000 00000001 0 00000000
# reset values
csr   300 0 00000000 00000000 00001800 0 00000000
csr   305 0 00000000 00000000 80000100 0 00000000
csr   341 0 00000000 00000000 00000000 0 00000000
csr   342 0 00000000 00000000 00000000 0 00000000
csr   340 0 00000000 00000000 00000000 0 00000000
csr   340 1 12345678 00000000 00000000 0 00000000
csr   340 0 00000000 00000000 12345678 0 00000000
csr   340 2 0000f000 00000000 12345678 0 00000000
csr   340 3 00000678 00000000 1234f678 0 00000000
csr   340 2 00000000 00000000 1234f000 0 00000000
csr   340 3 00000000 00000000 1234f000 0 00000000
csr   340 0 00000000 00000000 1234f000 0 00000000
csr   305 1 00000203 00000000 80000100 0 00000000
csr   305 2 80000000 00000000 00000203 0 00000000
csr   305 3 00000002 00000000 80000203 0 00000000
csr   305 0 00000000 00000000 80000201 0 00000000
csr   300 1 ffffffff 00000000 00001800 0 00000000
csr   300 0 00000000 00000000 00001888 0 00000000
csr   301 0 00000000 00000000 00000000 1 00000000
csr   344 1 ffffffff 00000000 00000000 1 00000000
csr   300 3 00000080 00000000 00001888 0 00000000
csr   300 0 00000000 00000000 00001808 0 00000000
# trap entry and return
ecall 000 0 00000000 00000400 00000000 0 80000200
csr   341 0 00000000 00000000 00000400 0 00000000
csr   342 0 00000000 00000000 0000000b 0 00000000
csr   300 0 00000000 00000000 00001880 0 00000000
csr   341 1 00000500 00000000 00000400 0 00000000
mret  000 0 00000000 00000000 00000000 0 00000500
csr   300 0 00000000 00000000 00001888 0 00000000
csr   300 1 00000000 00000000 00001888 0 00000000
mret  000 0 00000000 00000000 00000000 0 00000500
csr   300 0 00000000 00000000 00001880 0 00000000

//--- verification/tb_csr_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_csr_unit
    import csr_pkg::*;
();

    localparam xlen_t reset_mtvec  = 32'h8000_0100;
    localparam int    half_period  = 4;
    localparam int    drive_delay  = 1;
    localparam string pattern_file = "verification/csr_patterns.txt";

    logic      clk;
    logic      rst;
    logic      csr_valid;
    csr_addr_t csr_addr;
    csr_op_t   csr_op;
    xlen_t     csr_operand;
    logic      ecall;
    logic      mret;
    xlen_t     pc;
    xlen_t     csr_rdata;
    logic      csr_illegal;
    logic      busy;
    logic      redirect_valid;
    xlen_t     redirect_pc;

    // One entry per pattern line.
    string      kinds[$];
    csr_addr_t  addrs[$];
    logic [1:0] ops[$];
    xlen_t      operands[$];
    xlen_t      pcs[$];
    xlen_t      exp_rdatas[$];
    logic       exp_illegals[$];
    xlen_t      exp_targets[$];

    int cycles = 0;
    int timeout_limit = 0;

    csr_unit #(
        .reset_mtvec (reset_mtvec)
    ) csr_unit_inst (
        .clk            (clk),
        .rst            (rst),
        .csr_valid      (csr_valid),
        .csr_addr       (csr_addr),
        .csr_op         (csr_op),
        .csr_operand    (csr_operand),
        .ecall          (ecall),
        .mret           (mret),
        .pc             (pc),
        .csr_rdata      (csr_rdata),
        .csr_illegal    (csr_illegal),
        .busy           (busy),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_data(input string name, input xlen_t actual, input xlen_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %0t ns: %s expected %h, actual %h",
                $time, name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %0t ns: %s expected %b, actual %b",
                $time, name, expected, actual));
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (timeout_limit > 0 && cycles > timeout_limit) begin
            abort_run($sformatf("Run did not finish within %0d cycles.", timeout_limit));
        end
    end

    task automatic load_patterns();
        int         fd;
        int         fields;
        string      line;
        string      kind;
        csr_addr_t  addr;
        logic [1:0] op;
        xlen_t      operand;
        xlen_t      pc_value;
        xlen_t      rdata;
        logic       illegal;
        xlen_t      target;
        fd = $fopen(pattern_file, "r");
        if (fd == 0) begin
            abort_run({"Could not open the pattern file ", pattern_file, "."});
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin  // Skip comments and blanks.
                fields = $sscanf(line, "%s %h %h %h %h %h %h %h", kind, addr, op,
                    operand, pc_value, rdata, illegal, target);
                if (fields != 8) begin
                    abort_run({"Malformed pattern line: ", line});
                end
                kinds.push_back(kind);
                addrs.push_back(addr);
                ops.push_back(op);
                operands.push_back(operand);
                pcs.push_back(pc_value);
                exp_rdatas.push_back(rdata);
                exp_illegals.push_back(illegal);
                exp_targets.push_back(target);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_csr(input csr_addr_t addr, input logic [1:0] op, input xlen_t operand,
                           input xlen_t exp_rdata, input logic exp_illegal);
        csr_valid   = 1'b1;
        csr_addr    = addr;
        csr_op      = csr_op_t'(op);
        csr_operand = operand;
        @(negedge clk);
        check_data("csr_rdata", csr_rdata, exp_rdata);  // Old value, same cycle.
        check_flag("csr_illegal", csr_illegal, exp_illegal);
        check_flag("busy", busy, 1'b0);
        check_flag("redirect_valid", redirect_valid, 1'b0);
        @(posedge clk);
        #drive_delay;
        csr_valid   = 1'b0;
        csr_op      = csr_op_none;
        csr_operand = '0;
    endtask

    task automatic run_trap(input logic is_mret, input xlen_t pc_value, input xlen_t exp_target);
        int waited;
        ecall = !is_mret;
        mret  = is_mret;
        pc    = pc_value;
        @(posedge clk);
        #drive_delay;
        ecall = 1'b0;
        mret  = 1'b0;
        pc    = ~pc_value;  // The pc is only valid with the strobe.
        @(negedge clk);
        waited = 1;
        while (!redirect_valid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (!redirect_valid) begin
            abort_run("No redirect pulse followed the trap strobe.");
        end
        if (waited != 2) begin
            abort_run($sformatf("Redirect pulse came %0d cycles after the strobe, not 2.",
                waited));
        end
        check_data("redirect_pc", redirect_pc, exp_target);
        check_flag("busy", busy, 1'b1);
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic run_idle();
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("redirect_valid", redirect_valid, 1'b0);
        @(posedge clk);
        #drive_delay;
    endtask

    initial begin
        rst         = 1'b1;
        csr_valid   = 1'b0;
        csr_addr    = '0;
        csr_op      = csr_op_none;
        csr_operand = '0;
        ecall       = 1'b0;
        mret        = 1'b0;
        pc          = '0;
        load_patterns();
        if (kinds.size() == 0) begin
            abort_run("The pattern file holds no transactions.");
        end
        timeout_limit = kinds.size() * 4 + 20;
        repeat (3) @(posedge clk);
        #drive_delay;
        rst = 1'b0;
        foreach (kinds[i]) begin
            case (kinds[i])
                "csr":   run_csr(addrs[i], ops[i], operands[i], exp_rdatas[i], exp_illegals[i]);
                "ecall": run_trap(1'b0, pcs[i], exp_targets[i]);
                "mret":  run_trap(1'b1, pcs[i], exp_targets[i]);
                "idle":  run_idle();
                default: abort_run({"Unknown transaction kind ", kinds[i], "."});
            endcase
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire
